// File: files.f
hdl/ppu_pkg.sv
hdl/ppu_regs.sv
hdl/vram_arbiter.sv
hdl/ppu_background.sv
hdl/ppu_compositor.sv
hdl/ppu_top.sv
verif/ppu_assertions.sv
verif/ppu_tb.sv

// File: verif/ppu_trace.txt
# W addr data | R addr data resp | L beam_y | P count then index layer pairs | T name
# Addresses, data, beam_y and index are hex, count, resp and layer are decimal
W 1000 01030201
W 100C 04000000
W 1458 13121110
W 145C 17161514
W 1498 23222120
W 149C 27262524
W 14D8 33323130
W 14DC 37363534
W 148C ED000000
W 142C 87654321
W 144C 000000A9
W 1430 9ABCDEF8
W 1100 00000000
W 1800 00410040
W 1804 43000042
W 0000 00000001
W 0004 0000005A
W 0010 00000003
W 0014 00030005
W 0018 00000000
W 001C 00000010
R 0000 00000001 0
R 0004 0000005A 0
R 0010 00000003 0
R 0014 00030005 0
R 0018 00000000 0
R 001C 00000010 0
R 0008 00000000 0
R 0030 00000000 0
R 1000 00000000 2
T registers
L 0
P 24 15 0 16 0 17 0 20 0 21 0 22 0 23 0 24 0 25 0 26 0 27 0 30 0 31 0 32 0 33 0 34 0 35 0 36 0 37 0 10 0 11 0 12 0 13 0 14 0
T layer_8bpp
W 0010 00000001
W 0014 0003007E
L 0
P 12 0D 0 0E 0 01 0 02 0 03 0 04 0 05 0 06 0 07 0 08 0 09 0 0A 0
T layer_4bpp_wrap
W 0014 00030000
W 142C 00030021
W 0020 00000003
W 0024 00000000
W 0028 00000001
W 002C 00000020
L 0
P 8 01 0 02 0 41 1 5A 2 03 0 5A 2 5A 2 43 1
T two_layers
W 0020 00000000
L 0
P 2 01 0 02 0
L 1
P 8 08 0 0F 0 0E 0 0D 0 0C 0 0B 0 0A 0 09 0
T line_restart
W 0000 00000000
L 0
P 4 5A 2 5A 2 5A 2 5A 2
T global_disable

// File: verif/ppu_tb.sv
// Trace-driven testbench with AXI4-Lite driver, line control, pixel checker and watchdog
`timescale 1ns/1ps

module ppu_tb;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  awvalid, wvalid, bready, arvalid, rready;
	logic                  awready, wready, bvalid, arready, rvalid;
	logic [12:0]           awaddr, araddr;
	logic [31:0]           wdata, rdata;
	logic [3:0]            wstrb;
	logic [1:0]            bresp, rresp;
	logic                  line_start;
	logic [6:0]            beam_y;
	logic                  out_vld, out_rdy;
	ppu_pkg::pixel_t       out_pixel;
	integer                seed = 32'hcdb3;
	integer                errors = 0;
	integer                test_errors = 0;
	integer                tests_run = 0;
	integer                tests_failed = 0;
	integer                test_no = 1;
	integer                pixel_total = 0;
	integer                bus_total = 0;
	integer                limit_cycles = 0;

	always #20 clk = ~clk;

	ppu_top #(.NUM_LAYERS(2)) DUT (
		.clk(clk), .rst_n(rst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.line_start(line_start), .beam_y(beam_y),
		.out_vld(out_vld), .out_rdy(out_rdy), .out_pixel(out_pixel)
	);

	task count_error;
		errors++;
		test_errors++;
	endtask

	// ------------------------------
	// Bus and line drivers
	// ------------------------------

	// Handshakes are sampled just after the falling edge, ahead of the rising edge
	task axi_write(input logic [12:0] addr, input logic [31:0] data);
		@(negedge clk);
		awvalid = 1'b1;
		wvalid  = 1'b1;
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		#1;
		while (!awready) begin
			@(negedge clk);
			#1;
		end
		assert (wready) else begin
			$display("ERR t=%0t wready got %0b exp 1", $time, wready);
			count_error();
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			@(negedge clk);
		// The response is left waiting one cycle before it is taken
		@(negedge clk);
		assert (bresp == 2'b00) else begin
			$display("ERR t=%0t bresp got %0d exp 0", $time, bresp);
			count_error();
		end
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task axi_read(input logic [12:0] addr, input logic [31:0] exp_data, input integer exp_resp);
		@(negedge clk);
		arvalid = 1'b1;
		araddr  = addr;
		#1;
		while (!arready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		// Read data also has to wait one cycle for the master
		@(negedge clk);
		assert (rdata == exp_data) else begin
			$display("ERR t=%0t rdata got %h exp %h", $time, rdata, exp_data);
			count_error();
		end
		assert (rresp == exp_resp[1:0]) else begin
			$display("ERR t=%0t rresp got %0d exp %0d", $time, rresp, exp_resp);
			count_error();
		end
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task line_pulse(input logic [6:0] y);
		@(negedge clk);
		line_start = 1'b1;
		beam_y     = y;
		@(negedge clk);
		line_start = 1'b0;
	endtask

	// Test 3 runs without back-pressure, the others toss a coin each cycle
	task collect_pixel(input logic [7:0] exp_index, input integer exp_layer);
		logic   taken;
		integer r;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			r       = $random(seed);
			out_rdy = (test_no == 3) ? 1'b1 : r[0];
			#1;
			if (out_vld && out_rdy)
				taken = 1'b1;
		end
		assert (out_pixel.index == exp_index) else begin
			$display("ERR t=%0t out_pixel.index got %h exp %h", $time, out_pixel.index, exp_index);
			count_error();
		end
		assert (out_pixel.layer == exp_layer[1:0]) else begin
			$display("ERR t=%0t out_pixel.layer got %0d exp %0d", $time, out_pixel.layer, exp_layer);
			count_error();
		end
	endtask

	task end_test(input reg [8*40-1:0] name);
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %0d %0s: ok", test_no, name);
		end else begin
			$display("Test %0d %0s: failed with %0d errors", test_no, name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
		test_no++;
	endtask

	// ------------------------------
	// Trace reader
	// ------------------------------

	// A first pass only counts the work, so the watchdog can be sized
	task run_trace(input bit execute);
		integer           fd, code, i, n, resp, lay;
		logic [31:0]      a, d;
		logic [7:0]       idx;
		reg [8*16-1:0]    cmd;
		reg [8*40-1:0]    name;
		reg [8*256-1:0]   rest;
		bit               done;
		done = 1'b0;
		fd   = $fopen("verif/ppu_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file");
			count_error();
			done = 1'b1;
		end
		while (!done) begin
			code = $fscanf(fd, " %s", cmd);
			if (code != 1) begin
				done = 1'b1;
			end else begin
				case (cmd)
					"#": code = $fgets(rest, fd);
					"W": begin
						code = $fscanf(fd, "%h %h", a, d);
						if (execute) axi_write(a[12:0], d);
						else bus_total++;
					end
					"R": begin
						code = $fscanf(fd, "%h %h %d", a, d, resp);
						if (execute) axi_read(a[12:0], d, resp);
						else bus_total++;
					end
					"L": begin
						code = $fscanf(fd, "%h", a);
						if (execute) line_pulse(a[6:0]);
						else bus_total++;
					end
					"P": begin
						code = $fscanf(fd, "%d", n);
						for (i = 0; i < n; i++) begin
							code = $fscanf(fd, "%h %d", idx, lay);
							if (execute) collect_pixel(idx, lay);
							else pixel_total++;
						end
						// Nothing is taken outside a pixel check
						if (execute) begin
							@(negedge clk);
							out_rdy = 1'b0;
						end
					end
					"T": begin
						code = $fscanf(fd, "%s", name);
						if (execute) end_test(name);
					end
					default: begin
						$display("Unknown command %0s in the trace", cmd);
						count_error();
						done = 1'b1;
					end
				endcase
			end
		end
		if (fd != 0)
			$fclose(fd);
	endtask

	// ------------------------------
	// Main sequence and watchdog
	// ------------------------------

	initial begin
		rst_n      = 1'b0;
		awvalid    = 1'b0;
		wvalid     = 1'b0;
		awaddr     = '0;
		wdata      = '0;
		wstrb      = '0;
		bready     = 1'b0;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b0;
		line_start = 1'b0;
		beam_y     = '0;
		out_rdy    = 1'b0;
		run_trace(1'b0);
		limit_cycles = 200 * pixel_total + 20 * bus_total + 10;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		run_trace(1'b1);
		if (DUT.u_assertions.fail_count != 0) begin
			$display("Bound assertions failed %0d times", DUT.u_assertions.fail_count);
			errors = errors + DUT.u_assertions.fail_count;
		end
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles without the trace finishing", limit_cycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: verif/ppu_assertions.sv
// Concurrent assertions on bus handshakes, pixel stream stability and fetch grants
`timescale 1ns/1ps

module ppu_assertions #(
	parameter int NUM_LAYERS = 2
) (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  awvalid,
	input logic                  awready,
	input logic                  bvalid,
	input logic                  bready,
	input logic                  rvalid,
	input logic                  rready,
	input logic                  line_start,
	input logic                  out_vld,
	input logic                  out_rdy,
	input ppu_pkg::pixel_t       out_pixel,
	input ppu_pkg::vram_wr_t     vram_wr,
	input ppu_pkg::fetch_req_t   req [NUM_LAYERS],
	input logic [NUM_LAYERS-1:0] grant
);

	logic [NUM_LAYERS-1:0] req_vld;
	int unsigned           fail_count = 0;

	// Request bits gathered so each grant can be matched to a request
	always_comb begin
		for (int i = 0; i < NUM_LAYERS; i++)
			req_vld[i] = req[i].vld;
	end

	// Responses stay up until the master takes them
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			fail_count++;
		end

	// A line start or a register write may legally replace a waiting pixel
	a_pixel_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_vld && !out_rdy && !line_start && !(awvalid && awready) |=> $stable(out_pixel))
		else begin
			$error("out_pixel changed while stalled");
			fail_count++;
		end

	// One grant at most, only to a layer that asks and never in a bus write cycle
	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant) && (grant & ~req_vld) == '0 && !(vram_wr.vld && grant != '0))
		else begin
			$error("bad fetch grant");
			fail_count++;
		end

	// First edge out of reset sees idle response channels and no grant
	a_reset_idle: assert property (@(posedge clk)
		$rose(rst_n) |-> !bvalid && !rvalid && grant == '0)
		else begin
			$error("busy after reset");
			fail_count++;
		end

endmodule

bind ppu_top ppu_assertions #(.NUM_LAYERS(NUM_LAYERS)) u_assertions (
	.clk(clk), .rst_n(rst_n), .awvalid(awvalid), .awready(awready),
	.bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
	.line_start(line_start), .out_vld(out_vld), .out_rdy(out_rdy),
	.out_pixel(out_pixel), .vram_wr(vram_wr), .req(req), .grant(grant)
);

// File: hdl/ppu_top.sv
// Top level of the background renderer with registers, VRAM arbiter, layers and compositor
`timescale 1ns/1ps

module ppu_top #(
	parameter int NUM_LAYERS = 2
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [12:0]                 awaddr,
	input  logic                        wvalid,
	output logic                        wready,
	input  logic [31:0]                 wdata,
	input  logic [3:0]                  wstrb,
	output logic                        bvalid,
	input  logic                        bready,
	output logic [1:0]                  bresp,
	input  logic                        arvalid,
	output logic                        arready,
	input  logic [12:0]                 araddr,
	output logic                        rvalid,
	input  logic                        rready,
	output logic [31:0]                 rdata,
	output logic [1:0]                  rresp,
	input  logic                        line_start,
	input  logic [ppu_pkg::COORD_W-1:0] beam_y,
	output logic                        out_vld,
	input  logic                        out_rdy,
	output ppu_pkg::pixel_t             out_pixel
);

	logic                  enable;
	logic [7:0]            backdrop;
	ppu_pkg::layer_cfg_t   layer_cfg [NUM_LAYERS];
	ppu_pkg::vram_wr_t     vram_wr;
	ppu_pkg::fetch_req_t   req [NUM_LAYERS];
	ppu_pkg::fetch_rsp_t   rsp [NUM_LAYERS];
	logic [NUM_LAYERS-1:0] grant;
	logic [NUM_LAYERS-1:0] layer_en;
	logic [NUM_LAYERS-1:0] pix_vld;
	logic [7:0]            pix_index [NUM_LAYERS];
	logic                  pix_rdy;

	ppu_regs #(.NUM_LAYERS(NUM_LAYERS)) u_regs (
		.clk(clk), .rst_n(rst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.enable(enable), .backdrop(backdrop), .layer_cfg(layer_cfg), .vram_wr(vram_wr)
	);

	vram_arbiter #(.NUM_LAYERS(NUM_LAYERS)) u_arbiter (
		.clk(clk), .rst_n(rst_n), .vram_wr(vram_wr),
		.req(req), .grant(grant), .rsp(rsp)
	);

	// One engine per layer, all sharing the line control
	for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
		assign layer_en[i] = enable && layer_cfg[i].en;

		ppu_background u_bg (
			.clk(clk), .rst_n(rst_n), .enable(enable), .cfg(layer_cfg[i]),
			.line_start(line_start), .beam_y(beam_y),
			.req(req[i]), .grant(grant[i]), .rsp(rsp[i]),
			.pix_vld(pix_vld[i]), .pix_rdy(pix_rdy), .pix_index(pix_index[i])
		);
	end

	ppu_compositor #(.NUM_LAYERS(NUM_LAYERS)) u_comp (
		.layer_en(layer_en), .backdrop(backdrop),
		.pix_vld(pix_vld), .pix_index(pix_index), .pix_rdy(pix_rdy),
		.out_rdy(out_rdy), .out_vld(out_vld), .out_pixel(out_pixel)
	);

endmodule

// File: hdl/ppu_compositor.sv
// Compositor that joins the layer pixel streams and keeps the visible index
`timescale 1ns/1ps

module ppu_compositor #(
	parameter int NUM_LAYERS = 2
) (
	input  logic [NUM_LAYERS-1:0] layer_en,
	input  logic [7:0]            backdrop,
	input  logic [NUM_LAYERS-1:0] pix_vld,
	input  logic [7:0]            pix_index [NUM_LAYERS],
	output logic                  pix_rdy,
	input  logic                  out_rdy,
	output logic                  out_vld,
	output ppu_pkg::pixel_t       out_pixel
);

	// A disabled layer never holds the output back, so with all layers off
	// the backdrop streams out at once
	assign out_vld = &(pix_vld | ~layer_en);

	// Every enabled layer is popped on the same transfer
	assign pix_rdy = out_vld && out_rdy;

	// Walk from the back so the lowest-numbered opaque layer ends on top.
	// Index 0 is transparent.
	always_comb begin
		out_pixel.index = backdrop;
		out_pixel.layer = 2'(NUM_LAYERS);
		for (int i = NUM_LAYERS - 1; i >= 0; i--) begin
			if (layer_en[i] && pix_index[i] != 8'd0) begin
				out_pixel.index = pix_index[i];
				out_pixel.layer = 2'(i);
			end
		end
	end

endmodule

// File: hdl/ppu_background.sv
// Background layer engine with tile entry fetch, tile row fetch and pixel shift-out
`timescale 1ns/1ps

module ppu_background (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        enable,
	input  ppu_pkg::layer_cfg_t         cfg,
	input  logic                        line_start,
	input  logic [ppu_pkg::COORD_W-1:0] beam_y,
	output ppu_pkg::fetch_req_t         req,
	input  logic                        grant,
	input  ppu_pkg::fetch_rsp_t         rsp,
	output logic                        pix_vld,
	input  logic                        pix_rdy,
	output logic [7:0]                  pix_index
);

	logic [ppu_pkg::COORD_W-1:0] u;
	logic [ppu_pkg::COORD_W-1:0] v;
	logic                        tile_full_q;
	logic [7:0]                  tile_q;
	logic                        buf_full_q;
	logic [31:0]                 buf_q;
	logic                        held_q;
	logic [ppu_pkg::VRAM_AW-1:0] held_addr_q;
	logic                        stale_q;
	logic                        drop_q;
	logic                        inflight_q;
	logic                        want;
	logic                        rsp_ok;
	logic                        pop;
	logic                        word_end;
	logic                        mode_8bpp;
	logic [11:0]                 map_byte;
	logic [11:0]                 row_byte;
	logic [ppu_pkg::VRAM_AW-1:0] calc_addr;

	assign mode_8bpp = (cfg.mode == ppu_pkg::PIX_8BPP);

	// ----------------------------
	// Address generation
	// ----------------------------

	// Map entry is one byte per tile, 16 entries per map row
	assign map_byte = {cfg.map_base, v[6:3], u[6:3]};

	// An 8bpp row is 8 bytes over two words, a 4bpp row is one whole word
	assign row_byte = mode_8bpp
		? {cfg.set_base, 6'd0} + {tile_q[5:0], 6'd0} + {6'd0, v[2:0], u[2:0]}
		: {cfg.set_base, 6'd0} + {tile_q[6:0], 5'd0} + {7'd0, v[2:0], u[2:1]};

	// The tile entry has to be known before its row can be fetched
	assign calc_addr = tile_full_q ? row_byte[11:2] : map_byte[11:2];

	// ----------------------------
	// Fetch handshake
	// ----------------------------

	// No new fetch while a granted one has yet to answer
	assign want = enable && cfg.en && !inflight_q && (!tile_full_q || !buf_full_q);

	// An ungranted request is frozen until the arbiter takes it, even across
	// a line start
	assign req.vld  = held_q || want;
	assign req.addr = held_q ? held_addr_q : calc_addr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			held_q     <= 1'b0;
			stale_q    <= 1'b0;
			drop_q     <= 1'b0;
			inflight_q <= 1'b0;
		end else begin
			held_q     <= req.vld && !grant;
			inflight_q <= req.vld && grant;
			// Answers to fetches issued before the flush are thrown away
			drop_q     <= req.vld && grant && (stale_q || line_start);
			if (line_start && req.vld && !grant)
				stale_q <= 1'b1;
			else if (grant)
				stale_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req.vld && !grant)
			held_addr_q <= req.addr;
	end

	assign rsp_ok = rsp.vld && !drop_q;

	// ----------------------------
	// Coordinates and buffers
	// ----------------------------

	assign pop      = pix_vld && pix_rdy;
	assign word_end = mode_8bpp ? (u[1:0] == 2'd3) : (u[2:0] == 3'd7);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			u           <= '0;
			v           <= '0;
			tile_full_q <= 1'b0;
			buf_full_q  <= 1'b0;
		end else if (line_start) begin
			u           <= cfg.scroll_x;
			v           <= beam_y + cfg.scroll_y;
			tile_full_q <= 1'b0;
			buf_full_q  <= 1'b0;
		end else begin
			// The tile register always fills first, so the kind of answer
			// follows from which one is empty
			if (rsp_ok && !tile_full_q)
				tile_full_q <= 1'b1;
			else if (rsp_ok)
				buf_full_q <= 1'b1;
			if (pop) begin
				u <= u + 1'b1;
				if (word_end)
					buf_full_q <= 1'b0;
				if (u[2:0] == 3'd7)
					tile_full_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_ok && !tile_full_q)
			tile_q <= rsp.data[{u[4:3], 3'b000} +: 8];
		if (rsp_ok && tile_full_q)
			buf_q <= rsp.data;
	end

	// Low bits of u select the pixel, little-endian and low nibble first
	assign pix_vld   = buf_full_q;
	assign pix_index = mode_8bpp ? buf_q[{u[1:0], 3'b000} +: 8]
		: {4'd0, buf_q[{u[2:0], 2'b00} +: 4]};

endmodule

// File: hdl/vram_arbiter.sv
// VRAM storage with bus write priority and round-robin word fetch arbitration
`timescale 1ns/1ps

module vram_arbiter #(
	parameter int NUM_LAYERS = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	input  ppu_pkg::vram_wr_t   vram_wr,
	input  ppu_pkg::fetch_req_t req [NUM_LAYERS],
	output logic [NUM_LAYERS-1:0] grant,
	output ppu_pkg::fetch_rsp_t rsp [NUM_LAYERS]
);

	localparam int IDX_W = (NUM_LAYERS > 1) ? $clog2(NUM_LAYERS) : 1;

	logic [31:0]           mem [ppu_pkg::VRAM_WORDS];
	logic [IDX_W-1:0]      last_q;
	logic [IDX_W-1:0]      pick;
	logic                  any_req;
	logic [NUM_LAYERS-1:0] rsp_vld_q;
	logic [31:0]           rd_data_q;

	// ----------------------------
	// Arbitration
	// ----------------------------

	// Search starts at the layer after the last one served, so each
	// requester waits at most NUM_LAYERS-1 read slots. A pending bus write
	// owns the cycle and no grant is given.
	always_comb begin
		int idx;
		grant   = '0;
		pick    = last_q;
		any_req = 1'b0;
		for (int k = 1; k <= NUM_LAYERS; k++) begin
			idx = (int'(last_q) + k) % NUM_LAYERS;
			if (!any_req && !vram_wr.vld && req[idx].vld) begin
				any_req = 1'b1;
				pick    = IDX_W'(idx);
			end
		end
		grant[pick] = any_req;
	end

	// Layer 0 is first in line after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_q    <= IDX_W'(NUM_LAYERS - 1);
			rsp_vld_q <= '0;
		end else begin
			rsp_vld_q <= grant;
			if (any_req)
				last_q <= pick;
		end
	end

	// ----------------------------
	// Storage
	// ----------------------------

	// One port, so a cycle is either a byte-masked write or a word read
	always_ff @(posedge clk) begin
		if (vram_wr.vld) begin
			for (int b = 0; b < 4; b++) begin
				if (vram_wr.strb[b])
					mem[vram_wr.addr][b*8 +: 8] <= vram_wr.data[b*8 +: 8];
			end
		end else if (any_req) begin
			rd_data_q <= mem[req[pick].addr];
		end
	end

	// Read data is broadcast, the valid bit tells each layer it is theirs
	always_comb begin
		for (int i = 0; i < NUM_LAYERS; i++) begin
			rsp[i].vld  = rsp_vld_q[i];
			rsp[i].data = rd_data_q;
		end
	end

endmodule

// File: hdl/ppu_regs.sv
// AXI4-Lite register slave with control, backdrop, layer registers and VRAM write window
`timescale 1ns/1ps

module ppu_regs #(
	parameter int NUM_LAYERS = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                awvalid,
	output logic                awready,
	input  logic [12:0]         awaddr,
	input  logic                wvalid,
	output logic                wready,
	input  logic [31:0]         wdata,
	input  logic [3:0]          wstrb,
	output logic                bvalid,
	input  logic                bready,
	output logic [1:0]          bresp,
	input  logic                arvalid,
	output logic                arready,
	input  logic [12:0]         araddr,
	output logic                rvalid,
	input  logic                rready,
	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output logic                enable,
	output logic [7:0]          backdrop,
	output ppu_pkg::layer_cfg_t layer_cfg [NUM_LAYERS],
	output ppu_pkg::vram_wr_t   vram_wr
);

	// Only the layer slots that exist in the register map are decoded
	localparam int LAYERS = (NUM_LAYERS < ppu_pkg::MAX_LAYERS) ? NUM_LAYERS : ppu_pkg::MAX_LAYERS;

	logic                        aw_hs;
	logic                        ar_hs;
	logic                        enable_q;
	logic [7:0]                  backdrop_q;
	ppu_pkg::layer_cfg_t         cfg_q [NUM_LAYERS];
	logic                        wr_vld_q;
	logic [ppu_pkg::VRAM_AW-1:0] wr_addr_q;
	logic [31:0]                 wr_data_q;
	logic [3:0]                  wr_strb_q;
	logic [31:0]                 rd_word;
	logic [31:0]                 rdata_q;
	ppu_pkg::axi_resp_e          rresp_q;

	// ----------------------------
	// Write channel
	// ----------------------------

	// Address and data are taken together, and only with no response outstanding
	assign aw_hs   = awvalid && wvalid && !bvalid;
	assign awready = aw_hs;
	assign wready  = aw_hs;
	assign bresp   = ppu_pkg::RESP_OKAY;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid   <= 1'b0;
			wr_vld_q <= 1'b0;
		end else begin
			if (aw_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			// VRAM window writes leave as a single-cycle pulse
			wr_vld_q <= aw_hs && awaddr[12];
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs) begin
			wr_addr_q <= awaddr[11:2];
			wr_data_q <= wdata;
			wr_strb_q <= wstrb;
		end
	end

	assign vram_wr = '{vld: wr_vld_q, addr: wr_addr_q, data: wr_data_q, strb: wr_strb_q};

	// ----------------------------
	// Register file
	// ----------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable_q   <= 1'b0;
			backdrop_q <= '0;
			for (int n = 0; n < NUM_LAYERS; n++)
				cfg_q[n] <= '0;
		end else if (aw_hs && !awaddr[12]) begin
			// Slot 0 holds CTRL and BACKDROP
			if (awaddr[11:4] == 8'd0 && wstrb[0]) begin
				if (awaddr[3:2] == 2'd0)
					enable_q <= wdata[0];
				if (awaddr[3:2] == 2'd1)
					backdrop_q <= wdata[7:0];
			end
			// Slot n+1 holds the four registers of layer n
			for (int n = 0; n < LAYERS; n++) begin
				if (awaddr[11:4] == 8'(n + 1)) begin
					case (awaddr[3:2])
						2'd0: if (wstrb[0]) begin
							cfg_q[n].en   <= wdata[0];
							cfg_q[n].mode <= ppu_pkg::pix_mode_e'(wdata[1]);
						end
						2'd1: begin
							if (wstrb[0])
								cfg_q[n].scroll_x <= wdata[6:0];
							if (wstrb[2])
								cfg_q[n].scroll_y <= wdata[22:16];
						end
						2'd2: if (wstrb[0]) cfg_q[n].map_base <= wdata[3:0];
						default: if (wstrb[0]) cfg_q[n].set_base <= wdata[5:0];
					endcase
				end
			end
		end
	end

	assign enable    = enable_q;
	assign backdrop  = backdrop_q;
	assign layer_cfg = cfg_q;

	// ----------------------------
	// Read channel
	// ----------------------------

	// Unused bits and unmapped offsets read as zero
	always_comb begin
		rd_word = '0;
		if (araddr[11:4] == 8'd0) begin
			if (araddr[3:2] == 2'd0)
				rd_word[0] = enable_q;
			if (araddr[3:2] == 2'd1)
				rd_word[7:0] = backdrop_q;
		end
		for (int n = 0; n < LAYERS; n++) begin
			if (araddr[11:4] == 8'(n + 1)) begin
				case (araddr[3:2])
					2'd0: rd_word[1:0] = {cfg_q[n].mode, cfg_q[n].en};
					2'd1: begin
						rd_word[6:0]   = cfg_q[n].scroll_x;
						rd_word[22:16] = cfg_q[n].scroll_y;
					end
					2'd2: rd_word[3:0] = cfg_q[n].map_base;
					default: rd_word[5:0] = cfg_q[n].set_base;
				endcase
			end
		end
	end

	assign arready = !rvalid;
	assign ar_hs   = arvalid && arready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rvalid <= 1'b0;
		else if (ar_hs)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// The VRAM window cannot be read back
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rdata_q <= araddr[12] ? 32'd0 : rd_word;
			rresp_q <= araddr[12] ? ppu_pkg::RESP_SLVERR : ppu_pkg::RESP_OKAY;
		end
	end

	assign rdata = rdata_q;
	assign rresp = rresp_q;

endmodule

// File: hdl/ppu_pkg.sv
// Shared constants, enums and packed structs of the background renderer
package ppu_pkg;

	// ----------------------------
	// Sizes
	// ----------------------------

	// VRAM is 4 KiB organised as 32-bit words
	localparam int VRAM_WORDS = 1024;
	localparam int VRAM_AW    = 10;

	// Background coordinates wrap at 128 pixels (16 tiles of 8 pixels)
	localparam int COORD_W    = 7;

	// Layer slots reserved in the register map
	localparam int MAX_LAYERS = 4;

	// ----------------------------
	// Enums
	// ----------------------------

	typedef enum logic [0:0] {
		PIX_4BPP = 1'b0,
		PIX_8BPP = 1'b1
	} pix_mode_e;

	// AXI response codes used by the register slave
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	// ----------------------------
	// Structs
	// ----------------------------

	typedef struct packed {
		logic               en;
		pix_mode_e          mode;
		logic [COORD_W-1:0] scroll_x;
		logic [COORD_W-1:0] scroll_y;
		logic [3:0]         map_base;   // 256-byte units
		logic [5:0]         set_base;   // 64-byte units
	} layer_cfg_t;

	typedef struct packed {
		logic               vld;
		logic [VRAM_AW-1:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic        vld;
		logic [31:0] data;
	} fetch_rsp_t;

	typedef struct packed {
		logic               vld;
		logic [VRAM_AW-1:0] addr;
		logic [31:0]        data;
		logic [3:0]         strb;
	} vram_wr_t;

	// Layer value equal to the layer count marks the backdrop
	typedef struct packed {
		logic [7:0] index;
		logic [1:0] layer;
	} pixel_t;

endpackage
